// ==== Bender.yml ====
package:
  name: rv_pipe

sources:
  - common/rv_pipe_pkg.sv
  - logic/reg_file.sv
  - logic/fetch_stage.sv
  - execute/alu.sv
  - execute/branch_unit.sv
  - logic/bypass_unit.sv
  - logic/rv_pipe_core.sv
  - target: test
    files:
      - bench/rv_pipe_tb.sv

// ==== bench/rv_pipe_tb.sv ====
module rv_pipe_tb;

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    rv_pipe_pkg::word_t     pc;
    rv_pipe_pkg::word_t     insn;
    rv_pipe_pkg::reg_addr_t rd;
    rv_pipe_pkg::word_t     data;
    logic                   we;
    logic                   taken;
    logic                   is_halt;
  } wb_expect_t;

  localparam rv_pipe_pkg::word_t ecall_word = 32'h0000_0073;

  logic                       clk;
  logic                       rst;
  rv_pipe_pkg::word_t         pc_to_imem;
  rv_pipe_pkg::word_t         insn_from_imem;
  logic                       halt;
  rv_pipe_pkg::word_t         trace_wb_pc;
  rv_pipe_pkg::word_t         trace_wb_insn;
  rv_pipe_pkg::cycle_status_e trace_wb_status;
  rv_pipe_pkg::reg_addr_t     trace_wb_rd;
  rv_pipe_pkg::word_t         trace_wb_data;
  logic                       trace_wb_we;

  rv_pipe_pkg::word_t imem [0:63];
  rv_pipe_pkg::word_t model_regs [0:31];
  wb_expect_t         expect_q [$];
  int                 prog_len = 0;
  int                 errors = 0;

  rv_pipe_core #(.reset_pc(32'h0000_0000)) i_rv_pipe_core (
    .clk(clk), .rst(rst), .pc_to_imem(pc_to_imem), .insn_from_imem(insn_from_imem),
    .halt(halt), .trace_wb_pc(trace_wb_pc), .trace_wb_insn(trace_wb_insn),
    .trace_wb_status(trace_wb_status), .trace_wb_rd(trace_wb_rd),
    .trace_wb_data(trace_wb_data), .trace_wb_we(trace_wb_we)
  );

  // instruction memory answers in the same cycle, zero past the program
  always_comb begin
    if (pc_to_imem < rv_pipe_pkg::word_t'(prog_len * 4)) begin
      insn_from_imem = imem[pc_to_imem[7:2]];
    end else begin
      insn_from_imem = '0;
    end
  end

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic rv_pipe_pkg::word_t r_type(input logic [6:0] f7, input int rs2,
                                                input int rs1, input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_pipe_pkg::op_reg_reg};
  endfunction

  function automatic rv_pipe_pkg::word_t i_type(input logic [2:0] f3, input int rd, input int rs1,
                                                input logic [11:0] imm);
    return {imm, 5'(rs1), f3, 5'(rd), rv_pipe_pkg::op_reg_imm};
  endfunction

  function automatic rv_pipe_pkg::word_t b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                                input logic [12:0] off);
    return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], rv_pipe_pkg::op_branch};
  endfunction

  function automatic rv_pipe_pkg::word_t lui_word(input int rd, input logic [19:0] upper);
    return {upper, 5'(rd), rv_pipe_pkg::op_lui};
  endfunction

  task automatic append_insn(input rv_pipe_pkg::word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  task automatic load_program();
    logic [19:0] upper;
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [11:0] imm_c;
    logic [11:0] imm_d;
    upper = 20'($urandom);
    imm_a = 12'($urandom);
    imm_b = 12'($urandom);
    imm_c = 12'($urandom);
    imm_d = 12'($urandom);
    // dependent chains at distance one, two and three
    append_insn(lui_word(1, upper));
    append_insn(i_type(3'b000, 2, 1, imm_a));
    append_insn(i_type(3'b000, 3, 0, imm_b));
    append_insn(r_type(7'd0, 3, 2, 3'b000, 4));
    append_insn(r_type(rv_pipe_pkg::funct7_alt, 2, 4, 3'b000, 5));
    append_insn(r_type(7'd0, 3, 5, 3'b100, 6));
    append_insn(r_type(7'd0, 4, 6, 3'b110, 7));
    append_insn(r_type(7'd0, 5, 7, 3'b111, 8));
    append_insn(i_type(3'b001, 9, 8, {7'd0, 5'd7}));
    append_insn(i_type(3'b101, 13, 9, {7'd0, 5'd3}));
    append_insn(i_type(3'b101, 14, 1, {rv_pipe_pkg::funct7_alt, 5'd9}));
    append_insn(r_type(rv_pipe_pkg::funct7_alt, 3, 5, 3'b101, 15));
    append_insn(r_type(7'd0, 3, 5, 3'b101, 16));
    append_insn(r_type(7'd0, 3, 6, 3'b001, 17));
    append_insn(i_type(3'b010, 18, 5, imm_c));
    append_insn(i_type(3'b011, 19, 5, imm_d));
    append_insn(r_type(7'd0, 5, 4, 3'b010, 20));
    append_insn(r_type(7'd0, 5, 4, 3'b011, 21));
    append_insn(i_type(3'b100, 22, 21, imm_a));
    append_insn(i_type(3'b110, 23, 22, imm_b));
    append_insn(i_type(3'b111, 24, 23, imm_c));
    // x0 written, then read right away
    append_insn(i_type(3'b000, 0, 1, 12'd123));
    append_insn(r_type(7'd0, 1, 0, 3'b000, 25));
    append_insn(i_type(3'b000, 10, 0, 12'hffb));
    append_insn(i_type(3'b000, 11, 0, 12'd7));
    // each branch type, taken ones skip a poison write to x26
    append_insn(b_type(3'b000, 11, 11, 13'd8));
    append_insn(i_type(3'b000, 26, 0, 12'd1));
    append_insn(b_type(3'b001, 11, 11, 13'd8));
    append_insn(b_type(3'b100, 10, 11, 13'd8));
    append_insn(i_type(3'b000, 26, 0, 12'd2));
    append_insn(b_type(3'b110, 10, 11, 13'd8));
    append_insn(b_type(3'b110, 11, 10, 13'd8));
    append_insn(i_type(3'b000, 26, 0, 12'd5));
    append_insn(b_type(3'b101, 10, 11, 13'd8));
    append_insn(b_type(3'b101, 11, 10, 13'd8));
    append_insn(i_type(3'b000, 26, 0, 12'd3));
    append_insn(b_type(3'b111, 10, 11, 13'd8));
    append_insn(i_type(3'b000, 26, 0, 12'd4));
    // countdown loop with a backward branch
    append_insn(i_type(3'b000, 12, 0, 12'd3));
    append_insn(i_type(3'b000, 12, 12, 12'hfff));
    append_insn(b_type(3'b001, 12, 0, 13'h1ffc));
    append_insn(r_type(7'd0, 12, 26, 3'b000, 27));
    append_insn(ecall_word);
  endtask

  function automatic rv_pipe_pkg::word_t alu_model(input rv_pipe_pkg::word_t insn,
                                                   input rv_pipe_pkg::word_t a,
                                                   input rv_pipe_pkg::word_t b);
    logic is_rr;
    is_rr = (insn[6:0] == rv_pipe_pkg::op_reg_reg);
    if (insn[6:0] == rv_pipe_pkg::op_lui) begin
      return {insn[31:12], 12'h000};
    end
    case (insn[14:12])
      3'b000: return (is_rr && insn[30]) ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: return insn[30] ? rv_pipe_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input rv_pipe_pkg::word_t a,
                                        input rv_pipe_pkg::word_t b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // walk the program in order and queue what writeback should show
  task automatic run_model();
    rv_pipe_pkg::word_t pc;
    rv_pipe_pkg::word_t insn;
    rv_pipe_pkg::word_t a;
    rv_pipe_pkg::word_t b;
    wb_expect_t         e;
    pc = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int step = 0; step < 256; step++) begin
      insn = imem[pc[7:2]];
      a = model_regs[insn[19:15]];
      b = model_regs[insn[24:20]];
      e = '0;
      e.pc = pc;
      e.insn = insn;
      e.rd = insn[11:7];
      if (insn == ecall_word) begin
        e.is_halt = 1'b1;
        expect_q.push_back(e);
        break;
      end
      if (insn[6:0] == rv_pipe_pkg::op_branch) begin
        e.taken = branch_model(insn[14:12], a, b);
        expect_q.push_back(e);
        pc = e.taken ? pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0} : pc + 4;
      end else begin
        if (insn[6:0] == rv_pipe_pkg::op_reg_imm) begin
          b = {{20{insn[31]}}, insn[31:20]};
        end
        e.we = 1'b1;
        e.data = alu_model(insn, a, b);
        if (e.rd != '0) begin
          model_regs[e.rd] = e.data;
        end
        expect_q.push_back(e);
        pc = pc + 4;
      end
    end
  endtask

  task automatic check_word(input string what, input rv_pipe_pkg::word_t got,
                            input rv_pipe_pkg::word_t want);
    if (got !== want) begin
      errors++;
      $display("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_status(input string what, input rv_pipe_pkg::cycle_status_e got,
                              input rv_pipe_pkg::cycle_status_e want);
    if (got !== want) begin
      errors++;
      $display("Mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic want);
    if (got !== want) begin
      errors++;
      $display("Mismatch at %0d ns: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  task automatic check_reset_trace(input logic with_pc);
    check_status("reset status", trace_wb_status, rv_pipe_pkg::cycle_reset);
    check_bit("reset we", trace_wb_we, 1'b0);
    check_bit("reset halt", halt, 1'b0);
    if (with_pc) begin
      check_word("reset pc_to_imem", pc_to_imem, 32'h0000_0000);
    end
  endtask

  initial begin
    int         seed_ret;
    wb_expect_t e;
    seed_ret = $urandom(32'h6faa7f37);
    rst = 1'b1;
    load_program();
    run_model();
    for (int c = 0; c < 10; c++) begin
      @(posedge clk);
      #1;
      if (c == 9) begin
        rst = 1'b0;
      end
      check_reset_trace(1'b1);
    end
    // the pipeline drains its reset slots
    for (int c = 0; c < 4; c++) begin
      @(negedge clk);
      check_reset_trace(c == 0);
    end
    foreach (expect_q[i]) begin
      e = expect_q[i];
      @(negedge clk);
      check_status("status", trace_wb_status, rv_pipe_pkg::cycle_no_stall);
      check_word("pc", trace_wb_pc, e.pc);
      check_word("insn", trace_wb_insn, e.insn);
      check_bit("we", trace_wb_we, e.we);
      check_bit("halt", halt, e.is_halt);
      if (e.we) begin
        check_word("rd", rv_pipe_pkg::word_t'(trace_wb_rd), rv_pipe_pkg::word_t'(e.rd));
        check_word("data", trace_wb_data, e.data);
      end
      if (e.taken) begin
        repeat (2) begin
          @(negedge clk);
          check_status("bubble status", trace_wb_status, rv_pipe_pkg::cycle_taken_branch);
          check_word("bubble insn", trace_wb_insn, '0);
          check_bit("bubble we", trace_wb_we, 1'b0);
          check_bit("bubble halt", halt, 1'b0);
        end
      end
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // watchdog sized from the program length
  initial begin
    #1;
    repeat (prog_len * 8 + 40) @(posedge clk);
    $display("timeout: the final ecall did not reach writeback in %0d cycles",
             prog_len * 8 + 40);
    $display("errors: %0d", errors);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== common/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    op_lui     = 7'b0110111,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_branch  = 7'b1100011,
    op_system  = 7'b1110011
  } opcode_e;

  // class of the slot seen in writeback, one hot apart from invalid
  typedef enum logic [2:0] {
    cycle_invalid      = 3'd0,
    cycle_reset        = 3'd1,
    cycle_no_stall     = 3'd2,
    cycle_taken_branch = 3'd4
  } cycle_status_e;

  typedef enum logic [2:0] {
    alu_add  = 3'b000,
    alu_sll  = 3'b001,
    alu_slt  = 3'b010,
    alu_sltu = 3'b011,
    alu_xor  = 3'b100,
    alu_srl  = 3'b101,
    alu_or   = 3'b110,
    alu_and  = 3'b111
  } alu_funct3_e;

  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_funct3_e;

  // funct7 of sub, sra and srai
  localparam logic [6:0] funct7_alt = 7'b0100000;

endpackage

// ==== execute/alu.sv ====
module alu (
  input  rv_pipe_pkg::opcode_e opcode,
  input  logic [2:0]           funct3,
  input  logic [6:0]           funct7,
  input  rv_pipe_pkg::word_t   insn,
  input  rv_pipe_pkg::word_t   op_a,
  input  rv_pipe_pkg::word_t   op_b,
  output rv_pipe_pkg::word_t   result
);

  rv_pipe_pkg::word_t imm_i;
  rv_pipe_pkg::word_t src_b;
  rv_pipe_pkg::word_t sum;
  logic               is_reg_reg;
  logic               is_sub;
  logic               is_alt;
  logic [4:0]         shamt;

  assign imm_i = {{20{insn[31]}}, insn[31:20]};

  assign is_reg_reg = (opcode == rv_pipe_pkg::op_reg_reg);
  assign is_alt     = (funct7 == rv_pipe_pkg::funct7_alt);

  // immediate forms take the second operand from the instruction
  assign src_b = is_reg_reg ? op_b : imm_i;
  assign shamt = src_b[4:0];

  // subi does not exist, addi with a set bit 30 is still an add
  assign is_sub = is_reg_reg && is_alt;
  assign sum    = op_a + (is_sub ? ~src_b : src_b) + {31'd0, is_sub};

  always_comb begin
    result = '0;
    if (opcode == rv_pipe_pkg::op_lui) begin
      result = {insn[31:12], 12'd0};
    end else if (is_reg_reg || (opcode == rv_pipe_pkg::op_reg_imm)) begin
      case (rv_pipe_pkg::alu_funct3_e'(funct3))
        rv_pipe_pkg::alu_add: begin
          result = sum;
        end
        rv_pipe_pkg::alu_sll: begin
          result = op_a << shamt;
        end
        rv_pipe_pkg::alu_slt: begin
          result = {31'd0, $signed(op_a) < $signed(src_b)};
        end
        rv_pipe_pkg::alu_sltu: begin
          result = {31'd0, op_a < src_b};
        end
        rv_pipe_pkg::alu_xor: begin
          result = op_a ^ src_b;
        end
        rv_pipe_pkg::alu_srl: begin
          // sra and srai share the funct7 encoding
          result = is_alt ? rv_pipe_pkg::word_t'($signed(op_a) >>> shamt) : op_a >> shamt;
        end
        rv_pipe_pkg::alu_or: begin
          result = op_a | src_b;
        end
        rv_pipe_pkg::alu_and: begin
          result = op_a & src_b;
        end
        default: begin
          result = '0;
        end
      endcase
    end
  end

endmodule

// ==== execute/branch_unit.sv ====
module branch_unit (
  input  logic [2:0]         funct3,
  input  rv_pipe_pkg::word_t pc,
  input  rv_pipe_pkg::word_t insn,
  input  rv_pipe_pkg::word_t op_a,
  input  rv_pipe_pkg::word_t op_b,
  input  logic               is_branch,
  output logic               taken,
  output rv_pipe_pkg::word_t target
);

  rv_pipe_pkg::word_t imm_b;
  logic               eq;
  logic               lt;
  logic               ltu;
  logic               cond;

  // B-type immediate, always even
  assign imm_b  = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign target = pc + imm_b;

  assign eq  = (op_a == op_b);
  assign lt  = ($signed(op_a) < $signed(op_b));
  assign ltu = (op_a < op_b);

  always_comb begin
    case (rv_pipe_pkg::branch_funct3_e'(funct3))
      rv_pipe_pkg::br_beq:  cond = eq;
      rv_pipe_pkg::br_bne:  cond = !eq;
      rv_pipe_pkg::br_blt:  cond = lt;
      rv_pipe_pkg::br_bge:  cond = !lt;
      rv_pipe_pkg::br_bltu: cond = ltu;
      rv_pipe_pkg::br_bgeu: cond = !ltu;
      // funct3 010 and 011 are not branches
      default: cond = 1'b0;
    endcase
  end

  assign taken = is_branch && cond;

endmodule

// ==== logic/bypass_unit.sv ====
module bypass_unit (
  input  rv_pipe_pkg::reg_addr_t x_rs1,
  input  rv_pipe_pkg::reg_addr_t x_rs2,
  input  logic                   x_rs1_use,
  input  logic                   x_rs2_use,
  input  rv_pipe_pkg::word_t     x_rs1_data,
  input  rv_pipe_pkg::word_t     x_rs2_data,
  input  rv_pipe_pkg::reg_addr_t m_rd,
  input  logic                   m_rd_write,
  input  rv_pipe_pkg::word_t     m_data,
  input  rv_pipe_pkg::reg_addr_t w_rd,
  input  logic                   w_rd_write,
  input  rv_pipe_pkg::word_t     w_data,
  output rv_pipe_pkg::word_t     op_a,
  output rv_pipe_pkg::word_t     op_b
);

  // youngest producer wins, x0 is never forwarded
  function automatic rv_pipe_pkg::word_t pick(
    input rv_pipe_pkg::reg_addr_t src,
    input logic                   use_src,
    input rv_pipe_pkg::word_t     carried
  );
    if (use_src && (src != '0)) begin
      if (m_rd_write && (m_rd == src)) begin
        return m_data;
      end else if (w_rd_write && (w_rd == src)) begin
        return w_data;
      end
    end
    return carried;
  endfunction

  always_comb begin
    op_a = pick(x_rs1, x_rs1_use, x_rs1_data);
    op_b = pick(x_rs2, x_rs2_use, x_rs2_data);
  end

endmodule

// ==== logic/fetch_stage.sv ====
module fetch_stage #(
  parameter rv_pipe_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       redirect,
  input  rv_pipe_pkg::word_t         redirect_pc,
  input  rv_pipe_pkg::word_t         insn_from_imem,
  output rv_pipe_pkg::word_t         pc,
  output rv_pipe_pkg::word_t         fetch_insn,
  output rv_pipe_pkg::cycle_status_e fetch_status
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  // the word fetched under a taken branch is wrong path
  assign fetch_insn   = redirect ? '0 : insn_from_imem;
  assign fetch_status = redirect ? rv_pipe_pkg::cycle_taken_branch
                                 : rv_pipe_pkg::cycle_no_stall;

endmodule

// ==== logic/reg_file.sv ====
module reg_file (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_pipe_pkg::reg_addr_t rs1,
  input  rv_pipe_pkg::reg_addr_t rs2,
  output rv_pipe_pkg::word_t     rs1_data,
  output rv_pipe_pkg::word_t     rs2_data,
  input  rv_pipe_pkg::reg_addr_t rd,
  input  rv_pipe_pkg::word_t     rd_data,
  input  logic                   we
);

  // x0 has no storage
  rv_pipe_pkg::word_t regs [1:rv_pipe_pkg::num_regs-1];

  // same-cycle write is seen by the read, so decode gets writeback data
  function automatic rv_pipe_pkg::word_t read_port(input rv_pipe_pkg::reg_addr_t idx);
    if (idx == '0) begin
      return '0;
    end else if (we && (rd == idx)) begin
      return rd_data;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < rv_pipe_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

// ==== logic/rv_pipe_core.sv ====
module rv_pipe_core #(
  parameter rv_pipe_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  logic                       clk,
  input  logic                       rst,
  output rv_pipe_pkg::word_t         pc_to_imem,
  input  rv_pipe_pkg::word_t         insn_from_imem,
  output logic                       halt,
  output rv_pipe_pkg::word_t         trace_wb_pc,
  output rv_pipe_pkg::word_t         trace_wb_insn,
  output rv_pipe_pkg::cycle_status_e trace_wb_status,
  output rv_pipe_pkg::reg_addr_t     trace_wb_rd,
  output rv_pipe_pkg::word_t         trace_wb_data,
  output logic                       trace_wb_we
);

  rv_pipe_pkg::word_t fetch_insn, branch_target, rs1_data, rs2_data, op_a, op_b, alu_result;
  rv_pipe_pkg::cycle_status_e fetch_status;
  logic branch_taken, redirect, wb_we;

  rv_pipe_pkg::word_t d_pc, d_insn;
  rv_pipe_pkg::cycle_status_e d_status;
  rv_pipe_pkg::opcode_e d_opcode;
  rv_pipe_pkg::reg_addr_t d_rd, d_rs1, d_rs2;
  logic [2:0] d_funct3;
  logic [6:0] d_funct7;
  logic d_rd_write, d_rs1_use, d_rs2_use;

  rv_pipe_pkg::word_t x_pc, x_insn, x_rs1_data, x_rs2_data;
  rv_pipe_pkg::cycle_status_e x_status;
  rv_pipe_pkg::opcode_e x_opcode;
  rv_pipe_pkg::reg_addr_t x_rd, x_rs1, x_rs2;
  logic [2:0] x_funct3;
  logic [6:0] x_funct7;
  logic x_rd_write, x_rs1_use, x_rs2_use;

  rv_pipe_pkg::word_t m_pc, m_insn, m_data, w_pc, w_insn, w_data;
  rv_pipe_pkg::cycle_status_e m_status, w_status;
  rv_pipe_pkg::reg_addr_t m_rd, w_rd;
  logic m_rd_write, w_rd_write;

  fetch_stage #(.reset_pc(reset_pc)) i_fetch_stage (
    .clk(clk), .rst(rst), .redirect(redirect), .redirect_pc(branch_target),
    .insn_from_imem(insn_from_imem), .pc(pc_to_imem),
    .fetch_insn(fetch_insn), .fetch_status(fetch_status)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= rv_pipe_pkg::cycle_reset;
    end else begin
      d_pc     <= pc_to_imem;
      d_insn   <= fetch_insn;
      d_status <= fetch_status;
    end
  end

  // decode
  assign d_opcode = rv_pipe_pkg::opcode_e'(d_insn[6:0]);
  assign d_rd     = d_insn[11:7];
  assign d_funct3 = d_insn[14:12];
  assign d_rs1    = d_insn[19:15];
  assign d_rs2    = d_insn[24:20];
  assign d_funct7 = d_insn[31:25];

  assign d_rd_write = (d_opcode == rv_pipe_pkg::op_lui) || (d_opcode == rv_pipe_pkg::op_reg_imm)
                      || (d_opcode == rv_pipe_pkg::op_reg_reg);
  assign d_rs1_use  = (d_opcode == rv_pipe_pkg::op_reg_imm) || (d_opcode == rv_pipe_pkg::op_reg_reg)
                      || (d_opcode == rv_pipe_pkg::op_branch);
  assign d_rs2_use  = (d_opcode == rv_pipe_pkg::op_reg_reg) || (d_opcode == rv_pipe_pkg::op_branch);

  reg_file i_reg_file (
    .clk(clk), .rst(rst), .rs1(d_rs1), .rs2(d_rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rd(w_rd), .rd_data(w_data), .we(wb_we)
  );

  // execute register, decode slot becomes a bubble under a taken branch
  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      x_insn     <= '0;
      x_opcode   <= rv_pipe_pkg::opcode_e'(7'd0);
      x_rd_write <= 1'b0;
      x_rs1_use  <= 1'b0;
      x_rs2_use  <= 1'b0;
      x_status   <= rst ? rv_pipe_pkg::cycle_reset : rv_pipe_pkg::cycle_taken_branch;
    end else begin
      x_insn     <= d_insn;
      x_opcode   <= d_opcode;
      x_rd_write <= d_rd_write;
      x_rs1_use  <= d_rs1_use;
      x_rs2_use  <= d_rs2_use;
      x_status   <= d_status;
    end
    x_pc       <= d_pc;
    x_rd       <= d_rd;
    x_rs1      <= d_rs1;
    x_rs2      <= d_rs2;
    x_funct3   <= d_funct3;
    x_funct7   <= d_funct7;
    x_rs1_data <= rs1_data;
    x_rs2_data <= rs2_data;
  end

  bypass_unit i_bypass_unit (
    .x_rs1(x_rs1), .x_rs2(x_rs2), .x_rs1_use(x_rs1_use), .x_rs2_use(x_rs2_use),
    .x_rs1_data(x_rs1_data), .x_rs2_data(x_rs2_data),
    .m_rd(m_rd), .m_rd_write(m_rd_write), .m_data(m_data),
    .w_rd(w_rd), .w_rd_write(w_rd_write), .w_data(w_data), .op_a(op_a), .op_b(op_b)
  );

  alu i_alu (
    .opcode(x_opcode), .funct3(x_funct3), .funct7(x_funct7), .insn(x_insn),
    .op_a(op_a), .op_b(op_b), .result(alu_result)
  );

  branch_unit i_branch_unit (
    .funct3(x_funct3), .pc(x_pc), .insn(x_insn), .op_a(op_a), .op_b(op_b),
    .is_branch(x_opcode == rv_pipe_pkg::op_branch), .taken(branch_taken), .target(branch_target)
  );

  assign redirect = branch_taken && (x_status == rv_pipe_pkg::cycle_no_stall);

  // memory and writeback registers, no data access so both only carry the result
  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc <= '0;
      m_insn <= '0;
      m_rd <= '0;
      m_rd_write <= 1'b0;
      m_status <= rv_pipe_pkg::cycle_reset;
      w_pc <= '0;
      w_insn <= '0;
      w_rd <= '0;
      w_rd_write <= 1'b0;
      w_status <= rv_pipe_pkg::cycle_reset;
    end else begin
      m_pc <= x_pc;
      m_insn <= x_insn;
      m_rd <= x_rd;
      m_rd_write <= x_rd_write;
      m_status <= x_status;
      w_pc <= m_pc;
      w_insn <= m_insn;
      w_rd <= m_rd;
      w_rd_write <= m_rd_write;
      w_status <= m_status;
    end
    m_data <= alu_result;
    w_data <= m_data;
  end

  assign wb_we = w_rd_write && (w_status == rv_pipe_pkg::cycle_no_stall);
  // plain ecall only
  assign halt  = (w_status == rv_pipe_pkg::cycle_no_stall) && (w_insn[31:7] == 25'd0)
                 && (w_insn[6:0] == rv_pipe_pkg::op_system);

  assign trace_wb_pc     = w_pc;
  assign trace_wb_insn   = w_insn;
  assign trace_wb_status = w_status;
  assign trace_wb_rd     = w_rd;
  assign trace_wb_data   = w_data;
  assign trace_wb_we     = wb_we;

endmodule

// ==== rv_pipe.f ====
common/rv_pipe_pkg.sv
logic/reg_file.sv
logic/fetch_stage.sv
execute/alu.sv
execute/branch_unit.sv
logic/bypass_unit.sv
logic/rv_pipe_core.sv
bench/rv_pipe_tb.sv
